/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;

    // Single-byte opcodes handled by the implied-mode core
    localparam logic [data_w-1:0] op_asl_a = 8'h0A;
    localparam logic [data_w-1:0] op_rol_a = 8'h2A;
    localparam logic [data_w-1:0] op_lsr_a = 8'h4A;
    localparam logic [data_w-1:0] op_ror_a = 8'h6A;
    localparam logic [data_w-1:0] op_inx   = 8'hE8;
    localparam logic [data_w-1:0] op_iny   = 8'hC8;
    localparam logic [data_w-1:0] op_dex   = 8'hCA;
    localparam logic [data_w-1:0] op_dey   = 8'h88;
    localparam logic [data_w-1:0] op_tax   = 8'hAA;
    localparam logic [data_w-1:0] op_tay   = 8'hA8;
    localparam logic [data_w-1:0] op_tsx   = 8'hBA;
    localparam logic [data_w-1:0] op_txa   = 8'h8A;
    localparam logic [data_w-1:0] op_txs   = 8'h9A;
    localparam logic [data_w-1:0] op_tya   = 8'h98;
    localparam logic [data_w-1:0] op_sec   = 8'h38;
    localparam logic [data_w-1:0] op_sed   = 8'hF8;
    localparam logic [data_w-1:0] op_sei   = 8'h78;
    localparam logic [data_w-1:0] op_clc   = 8'h18;
    localparam logic [data_w-1:0] op_cld   = 8'hD8;
    localparam logic [data_w-1:0] op_cli   = 8'h58;
    localparam logic [data_w-1:0] op_clv   = 8'hB8;
    localparam logic [data_w-1:0] op_nop   = 8'hEA;

    localparam logic [data_w-1:0] sp_reset = 8'hFF;

    typedef enum logic {t0, t1} tstate_t;

    typedef enum logic [2:0] {sb_none, sb_acc, sb_x, sb_y, sb_sp, sb_alu} sb_src_t;
    typedef enum logic {alu_add, alu_rot} alu_op_t;
    typedef enum logic {a_sb, a_zero} alu_a_t;
    // ALU input B is always the DB bus, this picks what DB carries
    typedef enum logic [1:0] {db_from_acc, db_from_sb, db_all_ones} alu_b_t;
    typedef enum logic [1:0] {cin_zero, cin_one, cin_psr_carry} alu_cin_t;
    typedef enum logic [1:0] {psr_c, psr_d, psr_i, psr_v} psr_sel_t;

    typedef struct packed {
        sb_src_t  sb_src;
        alu_a_t   alu_a;
        alu_b_t   alu_b;
        alu_cin_t alu_cin;
        alu_op_t  alu_op;
        logic     load_alu;
        logic     load_acc;
        logic     load_x;
        logic     load_y;
        logic     load_sp;
        logic     carry_from_alu;
        logic     psr_write;
        psr_sel_t psr_sel;
        logic     psr_value;
        logic     pc_inc;
    } ctrl_t;

    typedef struct packed {
        logic [data_w-1:0] acc;
        logic [data_w-1:0] x;
        logic [data_w-1:0] y;
        logic [data_w-1:0] sp;
        logic              c;
        logic              d;
        logic              i;
        logic              v;
    } regs_t;

    // Idle word, every instruction starts from this
    localparam ctrl_t ctrl_nop = '{
        sb_src:  sb_none,
        alu_a:   a_sb,
        alu_b:   db_from_sb,
        alu_cin: cin_zero,
        alu_op:  alu_add,
        psr_sel: psr_c,
        default: 1'b0
    };

endpackage

/* rtl/sequencer.sv */
`timescale 1ns/1ps

module sequencer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::data_w-1:0] data,
    input  cpu_pkg::ctrl_t             ctrl,
    output cpu_pkg::tstate_t           state,
    output logic [cpu_pkg::data_w-1:0] ir,
    output logic [cpu_pkg::addr_w-1:0] pc
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cpu_pkg::t0;
            // Reset behaves as if a NOP had just been fetched
            ir    <= cpu_pkg::op_nop;
            pc    <= '0;
        end else begin
            if (state == cpu_pkg::t0) begin
                state <= cpu_pkg::t1;
            end else begin
                state <= cpu_pkg::t0;
                // Opcode fetch closes T1
                ir    <= data;
            end
            if (ctrl.pc_inc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // PC moves only across a T1 edge and only by one
    a_pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(pc) |-> ($past(state) == cpu_pkg::t1) && (pc == $past(pc) + 1'b1))
        else $error("pc changed outside T1 or by more than one, now %h", pc);

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  cpu_pkg::tstate_t          state,
    input  logic [cpu_pkg::data_w-1:0] ir,
    output cpu_pkg::ctrl_t            ctrl
);

    cpu_pkg::ctrl_t w0;
    cpu_pkg::ctrl_t w1;

    always_comb begin
        w0 = cpu_pkg::ctrl_nop;
        w1 = cpu_pkg::ctrl_nop;
        // Every T1 fetches the next opcode
        w1.pc_inc = 1'b1;
        case (ir)
            cpu_pkg::op_asl_a: begin
                w0.sb_src   = cpu_pkg::sb_acc;
                w0.alu_b    = cpu_pkg::db_from_acc;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_acc = 1'b1;
                w1.carry_from_alu = 1'b1;
            end
            cpu_pkg::op_rol_a: begin
                w0.sb_src   = cpu_pkg::sb_acc;
                w0.alu_b    = cpu_pkg::db_from_acc;
                w0.alu_cin  = cpu_pkg::cin_psr_carry;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_acc = 1'b1;
                w1.carry_from_alu = 1'b1;
            end
            cpu_pkg::op_lsr_a: begin
                w0.sb_src   = cpu_pkg::sb_acc;
                w0.alu_op   = cpu_pkg::alu_rot;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_acc = 1'b1;
                w1.carry_from_alu = 1'b1;
            end
            cpu_pkg::op_ror_a: begin
                w0.sb_src   = cpu_pkg::sb_acc;
                w0.alu_op   = cpu_pkg::alu_rot;
                w0.alu_cin  = cpu_pkg::cin_psr_carry;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_acc = 1'b1;
                w1.carry_from_alu = 1'b1;
            end
            // Increments run 0 + reg + 1 with the register on DB
            cpu_pkg::op_inx, cpu_pkg::op_iny: begin
                w0.sb_src   = (ir == cpu_pkg::op_inx) ? cpu_pkg::sb_x : cpu_pkg::sb_y;
                w0.alu_a    = cpu_pkg::a_zero;
                w0.alu_cin  = cpu_pkg::cin_one;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_x   = (ir == cpu_pkg::op_inx);
                w1.load_y   = (ir == cpu_pkg::op_iny);
            end
            // Decrements add all ones
            cpu_pkg::op_dex, cpu_pkg::op_dey: begin
                w0.sb_src   = (ir == cpu_pkg::op_dex) ? cpu_pkg::sb_x : cpu_pkg::sb_y;
                w0.alu_b    = cpu_pkg::db_all_ones;
                w0.load_alu = 1'b1;
                w1.sb_src   = cpu_pkg::sb_alu;
                w1.load_x   = (ir == cpu_pkg::op_dex);
                w1.load_y   = (ir == cpu_pkg::op_dey);
            end
            cpu_pkg::op_tax: begin
                w0.sb_src = cpu_pkg::sb_acc;
                w0.load_x = 1'b1;
            end
            cpu_pkg::op_tay: begin
                w0.sb_src = cpu_pkg::sb_acc;
                w0.load_y = 1'b1;
            end
            cpu_pkg::op_tsx: begin
                w0.sb_src = cpu_pkg::sb_sp;
                w0.load_x = 1'b1;
            end
            cpu_pkg::op_txa: begin
                w0.sb_src   = cpu_pkg::sb_x;
                w0.load_acc = 1'b1;
            end
            cpu_pkg::op_txs: begin
                w0.sb_src  = cpu_pkg::sb_x;
                w0.load_sp = 1'b1;
            end
            cpu_pkg::op_tya: begin
                w0.sb_src   = cpu_pkg::sb_y;
                w0.load_acc = 1'b1;
            end
            // Set and clear pairs take the flag value from opcode bit 5
            cpu_pkg::op_sec, cpu_pkg::op_clc: begin
                w0.psr_write = 1'b1;
                w0.psr_sel   = cpu_pkg::psr_c;
                w0.psr_value = ir[5];
            end
            cpu_pkg::op_sed, cpu_pkg::op_cld: begin
                w0.psr_write = 1'b1;
                w0.psr_sel   = cpu_pkg::psr_d;
                w0.psr_value = ir[5];
            end
            cpu_pkg::op_sei, cpu_pkg::op_cli: begin
                w0.psr_write = 1'b1;
                w0.psr_sel   = cpu_pkg::psr_i;
                w0.psr_value = ir[5];
            end
            // CLV only ever clears
            cpu_pkg::op_clv: begin
                w0.psr_write = 1'b1;
                w0.psr_sel   = cpu_pkg::psr_v;
            end
            default: begin
                // NOP and unknown opcodes keep the idle words
            end
        endcase
    end

    assign ctrl = (state == cpu_pkg::t0) ? w0 : w1;

    // The T0 word must not load the T1 write-back target
    // Sampled as T0 ends
    a_no_early_writeback: assert property (@(posedge state)
        w0.load_alu |-> !((w0.load_acc && w1.load_acc) || (w0.load_x && w1.load_x)
                          || (w0.load_y && w1.load_y) || (w0.load_sp && w1.load_sp)))
        else $error("decoder loads write-back register in T0 for opcode %h", ir);

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::data_w-1:0] sb,
    input  logic [cpu_pkg::data_w-1:0] db,
    input  logic                       carry,
    input  cpu_pkg::ctrl_t             ctrl,
    output logic [cpu_pkg::data_w-1:0] result,
    output logic                       carry_out
);

    logic [cpu_pkg::data_w-1:0] a;
    logic                       cin;
    logic [cpu_pkg::data_w:0]   sum;
    logic [cpu_pkg::data_w-1:0] res_d;
    logic                       co_d;

    always_comb begin
        a = (ctrl.alu_a == cpu_pkg::a_zero) ? '0 : sb;
        case (ctrl.alu_cin)
            cpu_pkg::cin_one:       cin = 1'b1;
            cpu_pkg::cin_psr_carry: cin = carry;
            default:                cin = 1'b0;
        endcase
        sum = {1'b0, a} + {1'b0, db} + {{cpu_pkg::data_w{1'b0}}, cin};
        if (ctrl.alu_op == cpu_pkg::alu_rot) begin
            // Right rotate through carry, old bit 0 drops out
            res_d = {cin, a[cpu_pkg::data_w-1:1]};
            co_d  = a[0];
        end else begin
            res_d = sum[cpu_pkg::data_w-1:0];
            co_d  = sum[cpu_pkg::data_w];
        end
    end

    // Holding register, loaded in T0 and read back onto SB in T1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result    <= '0;
            carry_out <= 1'b0;
        end else if (ctrl.load_alu) begin
            result    <= res_d;
            carry_out <= co_d;
        end
    end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cpu_pkg::ctrl_t             ctrl,
    input  logic [cpu_pkg::data_w-1:0] alu_result,
    input  logic                       alu_carry,
    output logic [cpu_pkg::data_w-1:0] sb,
    output logic [cpu_pkg::data_w-1:0] db,
    output logic                       carry,
    output cpu_pkg::regs_t             regs
);

    cpu_pkg::regs_t r_q;

    // Special bus source
    always_comb begin
        case (ctrl.sb_src)
            cpu_pkg::sb_acc: sb = r_q.acc;
            cpu_pkg::sb_x:   sb = r_q.x;
            cpu_pkg::sb_y:   sb = r_q.y;
            cpu_pkg::sb_sp:  sb = r_q.sp;
            cpu_pkg::sb_alu: sb = alu_result;
            default:         sb = '0;
        endcase
    end

    // Data bus feeds ALU input B
    always_comb begin
        case (ctrl.alu_b)
            cpu_pkg::db_from_acc: db = r_q.acc;
            cpu_pkg::db_all_ones: db = '1;
            default:              db = sb;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_q.acc <= '0;
            r_q.x   <= '0;
            r_q.y   <= '0;
            r_q.sp  <= cpu_pkg::sp_reset;
            r_q.c   <= 1'b0;
            r_q.d   <= 1'b0;
            r_q.i   <= 1'b0;
            r_q.v   <= 1'b0;
        end else begin
            // All register loads take the SB value
            if (ctrl.load_acc) begin
                r_q.acc <= sb;
            end
            if (ctrl.load_x) begin
                r_q.x <= sb;
            end
            if (ctrl.load_y) begin
                r_q.y <= sb;
            end
            if (ctrl.load_sp) begin
                r_q.sp <= sb;
            end
            // Shift write-back
            if (ctrl.carry_from_alu) begin
                r_q.c <= alu_carry;
            end
            if (ctrl.psr_write) begin
                case (ctrl.psr_sel)
                    cpu_pkg::psr_c: r_q.c <= ctrl.psr_value;
                    cpu_pkg::psr_d: r_q.d <= ctrl.psr_value;
                    cpu_pkg::psr_i: r_q.i <= ctrl.psr_value;
                    default:        r_q.v <= ctrl.psr_value;
                endcase
            end
        end
    end

    assign carry = r_q.c;
    assign regs  = r_q;

    // Index and stack registers share one SB cycle, the decoder never loads two
    a_single_index_load: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({ctrl.load_x, ctrl.load_y, ctrl.load_sp}))
        else $error("more than one of load_x, load_y, load_sp active");

endmodule

/* rtl/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [cpu_pkg::data_w-1:0] data,
    output logic [cpu_pkg::addr_w-1:0] addr,
    output logic                       sync,
    output cpu_pkg::regs_t             regs
);

    cpu_pkg::tstate_t           state;
    cpu_pkg::ctrl_t             ctrl;
    logic [cpu_pkg::data_w-1:0] ir;
    logic [cpu_pkg::addr_w-1:0] pc;
    logic [cpu_pkg::data_w-1:0] sb;
    logic [cpu_pkg::data_w-1:0] db;
    logic                       carry;
    logic [cpu_pkg::data_w-1:0] alu_result;
    logic                       alu_carry;

    sequencer u_sequencer (
        .clk    (clk),
        .arst_n (arst_n),
        .data   (data),
        .ctrl   (ctrl),
        .state  (state),
        .ir     (ir),
        .pc     (pc)
    );

    instr_decode u_instr_decode (
        .state (state),
        .ir    (ir),
        .ctrl  (ctrl)
    );

    alu u_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .sb        (sb),
        .db        (db),
        .carry     (carry),
        .ctrl      (ctrl),
        .result    (alu_result),
        .carry_out (alu_carry)
    );

    datapath u_datapath (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .alu_carry  (alu_carry),
        .sb         (sb),
        .db         (db),
        .carry      (carry),
        .regs       (regs)
    );

    // Fetch cycle is T1, the PC is the address
    assign sync = (state == cpu_pkg::t1);
    assign addr = pc;

endmodule

/* test/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int prog_len   = 200;
    localparam int max_cycles = prog_len * 2 + 50;

    logic                       clk;
    logic                       arst_n;
    logic [cpu_pkg::data_w-1:0] data;
    logic [cpu_pkg::addr_w-1:0] addr;
    logic                       sync;
    cpu_pkg::regs_t             regs;

    logic [cpu_pkg::data_w-1:0] prog [0:prog_len-1];
    logic [cpu_pkg::data_w-1:0] supported [0:21];
    logic [31:0]                rng;

    // Reference model state, advanced at the end of every T1
    cpu_pkg::regs_t             model;
    logic [cpu_pkg::data_w-1:0] cur_op;
    logic [cpu_pkg::data_w-1:0] last_op;
    int                         fetch_cnt;
    int                         cyc;
    int                         cycles;
    int                         reset_errors;
    int                         sync_errors;
    int                         addr_errors;
    int                         regs_errors;
    int                         total;

    cpu_core uut (
        .clk    (clk),
        .arst_n (arst_n),
        .data   (data),
        .addr   (addr),
        .sync   (sync),
        .regs   (regs)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic cpu_pkg::regs_t reset_state();
        cpu_pkg::regs_t r;
        r    = '0;
        r.sp = cpu_pkg::sp_reset;
        return r;
    endfunction

    // Architectural effect of one opcode, shifts written as 9-bit rotates
    function automatic cpu_pkg::regs_t execute(input cpu_pkg::regs_t r,
                                               input logic [7:0] op);
        cpu_pkg::regs_t n;
        n = r;
        case (op)
            cpu_pkg::op_asl_a: {n.c, n.acc} = {r.acc, 1'b0};
            cpu_pkg::op_rol_a: {n.c, n.acc} = {r.acc, r.c};
            cpu_pkg::op_lsr_a: {n.acc, n.c} = {1'b0, r.acc};
            cpu_pkg::op_ror_a: {n.acc, n.c} = {r.c, r.acc};
            cpu_pkg::op_inx:   n.x = r.x + 8'd1;
            cpu_pkg::op_iny:   n.y = r.y + 8'd1;
            cpu_pkg::op_dex:   n.x = r.x - 8'd1;
            cpu_pkg::op_dey:   n.y = r.y - 8'd1;
            cpu_pkg::op_tax:   n.x = r.acc;
            cpu_pkg::op_tay:   n.y = r.acc;
            cpu_pkg::op_tsx:   n.x = r.sp;
            cpu_pkg::op_txa:   n.acc = r.x;
            cpu_pkg::op_txs:   n.sp = r.x;
            cpu_pkg::op_tya:   n.acc = r.y;
            cpu_pkg::op_sec:   n.c = 1'b1;
            cpu_pkg::op_clc:   n.c = 1'b0;
            cpu_pkg::op_sed:   n.d = 1'b1;
            cpu_pkg::op_cld:   n.d = 1'b0;
            cpu_pkg::op_sei:   n.i = 1'b1;
            cpu_pkg::op_cli:   n.i = 1'b0;
            cpu_pkg::op_clv:   n.v = 1'b0;
            default:           n = r;
        endcase
        return n;
    endfunction

    function automatic string op_class(input logic [7:0] op);
        case (op)
            cpu_pkg::op_asl_a, cpu_pkg::op_rol_a,
            cpu_pkg::op_lsr_a, cpu_pkg::op_ror_a: return "shift";
            cpu_pkg::op_inx, cpu_pkg::op_iny,
            cpu_pkg::op_dex, cpu_pkg::op_dey:     return "inc_dec";
            cpu_pkg::op_tax, cpu_pkg::op_tay, cpu_pkg::op_tsx,
            cpu_pkg::op_txa, cpu_pkg::op_txs, cpu_pkg::op_tya: return "transfer";
            cpu_pkg::op_sec, cpu_pkg::op_clc, cpu_pkg::op_sed, cpu_pkg::op_cld,
            cpu_pkg::op_sei, cpu_pkg::op_cli, cpu_pkg::op_clv: return "flag_write";
            default: return "nop_or_unknown";
        endcase
    endfunction

    // Memory answers every fetch, past the program it returns NOP
    always @(posedge clk) begin
        data <= (int'(addr) < prog_len) ? prog[addr[7:0]] : cpu_pkg::op_nop;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            model     <= reset_state();
            cur_op    <= cpu_pkg::op_nop;
            last_op   <= cpu_pkg::op_nop;
            fetch_cnt <= 0;
            cyc       <= 0;
        end else begin
            cyc <= cyc + 1;
            if (sync) begin
                model     <= execute(model, cur_op);
                last_op   <= cur_op;
                cur_op    <= data;
                fetch_cnt <= fetch_cnt + 1;
            end
        end
    end

    a_reset_values: assert property (@(posedge clk) disable iff (!arst_n)
        (cyc == 0) |-> (regs == reset_state()))
        else begin
            reset_errors++;
            $display("error reset_values: expected %h actual %h",
                     reset_state(), $sampled(regs));
        end

    a_sync_toggle: assert property (@(posedge clk) disable iff (!arst_n)
        sync == cyc[0])
        else begin
            sync_errors++;
            $display("error sync_toggle: expected %b actual %b",
                     $sampled(cyc[0]), $sampled(sync));
        end

    a_fetch_addr: assert property (@(posedge clk) disable iff (!arst_n)
        sync |-> (addr == fetch_cnt[cpu_pkg::addr_w-1:0]))
        else begin
            addr_errors++;
            $display("error fetch_addr: expected %h actual %h",
                     $sampled(fetch_cnt[cpu_pkg::addr_w-1:0]), $sampled(addr));
        end

    // Full register view after each completed instruction, sampled in T0
    a_regs_match: assert property (@(posedge clk) disable iff (!arst_n)
        !sync |-> (regs == model))
        else begin
            regs_errors++;
            $display("error %s: expected %h actual %h",
                     op_class($sampled(last_op)), $sampled(model), $sampled(regs));
        end

    initial begin
        arst_n       = 1'b0;
        data         = cpu_pkg::op_nop;
        reset_errors = 0;
        sync_errors  = 0;
        addr_errors  = 0;
        regs_errors  = 0;
        supported = '{cpu_pkg::op_asl_a, cpu_pkg::op_rol_a, cpu_pkg::op_lsr_a,
                      cpu_pkg::op_ror_a, cpu_pkg::op_inx, cpu_pkg::op_iny,
                      cpu_pkg::op_dex, cpu_pkg::op_dey, cpu_pkg::op_tax,
                      cpu_pkg::op_tay, cpu_pkg::op_tsx, cpu_pkg::op_txa,
                      cpu_pkg::op_txs, cpu_pkg::op_tya, cpu_pkg::op_sec,
                      cpu_pkg::op_sed, cpu_pkg::op_sei, cpu_pkg::op_clc,
                      cpu_pkg::op_cld, cpu_pkg::op_cli, cpu_pkg::op_clv,
                      cpu_pkg::op_nop};
        // One byte in eight is arbitrary, the rest are supported opcodes
        rng = 32'd56;
        for (int k = 0; k < prog_len; k++) begin
            rng = xorshift(rng);
            if (rng[2:0] == 3'd0) begin
                prog[k] = rng[15:8];
            end else begin
                prog[k] = supported[rng[15:8] % 22];
            end
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 3;
        while (fetch_cnt < prog_len + 1 && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (fetch_cnt < prog_len + 1) begin
            $display("timeout: only %0d opcodes fetched after %0d cycles",
                     fetch_cnt, cycles);
            $display("Test failed");
        end else begin
            // Let the last instruction reach its T0 check
            repeat (2) @(posedge clk);
            total = reset_errors + sync_errors + addr_errors + regs_errors;
            $display("errors: reset %0d, sync %0d, addr %0d, regs %0d, total %0d",
                     reset_errors, sync_errors, addr_errors, regs_errors, total);
            if (total == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule

/* tb.f */
rtl/cpu_pkg.sv
rtl/sequencer.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/datapath.sv
rtl/cpu_core.sv
test/tb_cpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_cpu
RTL_TOP    ?= cpu_core
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
